// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_sgd_dot_product
FILELIST  = files.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the output for the pass line"
	@echo "  clean  remove build products"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_sgd_dot_product.sv ====
/*
 * tb_sgd_dot_product
 * random bit-plane samples and x chunks checked against a reference
 * model, with credit stalls, FIFO back-pressure and a watchdog
 */
module tb_sgd_dot_product;
    timeunit 1ns;
    timeprecision 1ps;
    import sgd_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int N_TESTS      = 4;
    localparam int MAX_SAMPLES  = 8;
    localparam int MAX_FEAT     = 32;   // four chunks
    localparam int STALL_CYCLES = 100;  // window with credits held

    // per test epochs, samples, dimension, bit-planes, prefill and credit hold
    int cfg_epochs  [N_TESTS] = '{1, 1, 3, 2};
    int cfg_samples [N_TESTS] = '{4, 6, 4, 4};
    int cfg_dim     [N_TESTS] = '{21, 13, 21, 10};
    int cfg_bits    [N_TESTS] = '{1, 4, 8, 4};
    bit cfg_prefill [N_TESTS] = '{0, 0, 1, 0};
    bit cfg_hold    [N_TESTS] = '{0, 0, 0, 1};

    logic                    clk;
    logic                    rst_n;
    logic                    started;
    logic [CFG_W-1:0]        number_of_epochs;
    logic [CFG_W-1:0]        number_of_samples;
    logic [CFG_W-1:0]        dimension;
    logic [CFG_W-1:0]        number_of_bits;
    logic [A_WORD_W-1:0]     dispatch_axb_a_data;
    logic                    dispatch_axb_a_wr_en;
    logic                    dispatch_axb_a_almost_full;
    logic [CREDIT_W-1:0]     x_wr_credit_counter;
    logic [X_ADDR_W-1:0]     x_rd_addr;
    logic [X_WORD_W-1:0]     x_rd_data = '0;
    logic signed [DOT_W-1:0] dot_product [NUM_BANKS];
    logic [NUM_BANKS-1:0]    dot_product_valid;

    logic [X_WORD_W-1:0]     x_mem [1 << X_ADDR_W];
    logic [7:0]              a_val [MAX_SAMPLES][MAX_FEAT];  // bit p is plane p
    logic [A_WORD_W-1:0]     word_q [$];                     // writer stream
    logic signed [DOT_W-1:0] exp_q [NUM_BANKS][$];
    int                      got_count [NUM_BANKS];
    logic [31:0]             rng_state = 32'h7b5b0db0;

    sgd_dot_product DUT (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .started                    (started),
        .number_of_epochs           (number_of_epochs),
        .number_of_samples          (number_of_samples),
        .dimension                  (dimension),
        .number_of_bits             (number_of_bits),
        .dispatch_axb_a_data        (dispatch_axb_a_data),
        .dispatch_axb_a_wr_en       (dispatch_axb_a_wr_en),
        .dispatch_axb_a_almost_full (dispatch_axb_a_almost_full),
        .x_wr_credit_counter        (x_wr_credit_counter),
        .x_rd_addr                  (x_rd_addr),
        .x_rd_data                  (x_rd_data),
        .dot_product                (dot_product),
        .dot_product_valid          (dot_product_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        x_rd_data <= x_mem[x_rd_addr];  // registered read with data one cycle later

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("[ERROR] %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic bit queues_empty();
        for (int b = 0; b < NUM_BANKS; b++)
            if (exp_q[b].size() != 0)
                return 1'b0;
        return 1'b1;
    endfunction

    // each plane sum weighted by 2^-(p+1) with FRAC_BITS extra fraction
    function automatic logic signed [DOT_W-1:0] expected_dot(input int s, input int t);
        logic signed [ACC_WIDTH-1:0] acc;
        logic signed [ACC_WIDTH-1:0] term;
        logic signed [X_WIDTH-1:0]   sum;
        int                          chunks;
        chunks = (cfg_dim[t] + BITS_PER_BANK - 1) / BITS_PER_BANK;
        acc    = '0;
        for (int c = 0; c < chunks; c++)
            for (int p = 0; p < cfg_bits[t]; p++)
            begin
                sum = '0;
                for (int j = 0; j < BITS_PER_BANK; j++)
                    if (a_val[s][c*BITS_PER_BANK+j][p])
                        sum += x_mem[c][j*X_WIDTH +: X_WIDTH];  // wraps at 32 bits
                term = sum;                  // sign extended
                term = term <<< FRAC_BITS;
                acc += term >>> (p + 1);
            end
        return acc[ACC_WIDTH-1 -: DOT_W];
    endfunction

    task automatic prepare_test(input int t);
        int                  chunks;
        int                  groups;
        logic [A_WORD_W-1:0] word;
        logic [31:0]         r;
        chunks = (cfg_dim[t] + BITS_PER_BANK - 1) / BITS_PER_BANK;
        groups = cfg_samples[t] / NUM_BANKS;
        for (int adr = 0; adr < (1 << X_ADDR_W); adr++)
            for (int j = 0; j < BITS_PER_BANK; j++)
                x_mem[adr][j*X_WIDTH +: X_WIDTH] = next_random();
        for (int s = 0; s < MAX_SAMPLES; s++)
            for (int f = 0; f < MAX_FEAT; f++)
            begin
                r           = next_random();
                a_val[s][f] = (f < cfg_dim[t]) ? r[7:0] : 8'h00;  // padding features zero
            end
        word_q.delete();
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            exp_q[b].delete();
            got_count[b] = 0;
        end
        // same samples every epoch with group g holding samples g*NUM_BANKS + bank
        for (int e = 0; e < cfg_epochs[t]; e++)
            for (int g = 0; g < groups; g++)
            begin
                for (int b = 0; b < NUM_BANKS; b++)
                    exp_q[b].push_back(expected_dot(g * NUM_BANKS + b, t));
                for (int c = 0; c < chunks; c++)
                    for (int p = 0; p < cfg_bits[t]; p++)
                    begin
                        word = '0;
                        for (int b = 0; b < NUM_BANKS; b++)
                            for (int j = 0; j < BITS_PER_BANK; j++)
                                word[b*BITS_PER_BANK+j] =
                                    a_val[g*NUM_BANKS+b][c*BITS_PER_BANK+j][p];
                        word_q.push_back(word);
                    end
            end
    endtask

    // stops on almost-full and leaves random idle gaps
    task automatic write_words();
        logic [31:0] r;
        while (word_q.size() != 0)
        begin
            @(negedge clk);
            r = next_random();
            if (dispatch_axb_a_almost_full || r[2:0] == 3'd0)
                dispatch_axb_a_wr_en = 1'b0;
            else
            begin
                dispatch_axb_a_data  = word_q.pop_front();
                dispatch_axb_a_wr_en = 1'b1;
            end
        end
        @(negedge clk);
        dispatch_axb_a_wr_en = 1'b0;
    endtask

    task automatic drive_run(input int t);
        int                  groups;
        logic [X_ADDR_W-1:0] held_addr;
        groups = cfg_epochs[t] * cfg_samples[t] / NUM_BANKS;
        if (cfg_prefill[t])
            while (!dispatch_axb_a_almost_full)
                @(negedge clk);  // FIFO fills ahead of start
        x_wr_credit_counter = cfg_hold[t] ? CREDIT_W'(1) : CREDIT_W'(groups);
        started             = 1'b1;
        if (cfg_hold[t])
        begin
            while (got_count[0] == 0 || got_count[NUM_BANKS-1] == 0)
                @(negedge clk);  // first group drained
            held_addr = x_rd_addr;
            repeat (STALL_CYCLES)
            begin
                @(negedge clk);
                check_equal(64'(x_rd_addr), 64'(held_addr), "x_rd_addr moved without credit");
                check_equal(64'(dot_product_valid), 64'd0, "result without credit");
            end
            x_wr_credit_counter = CREDIT_W'(groups);  // release the rest
        end
        while (!queues_empty())
            @(negedge clk);
    endtask

    task automatic run_test(input int t);
        number_of_epochs     = CFG_W'(cfg_epochs[t]);
        number_of_samples    = CFG_W'(cfg_samples[t]);
        dimension            = CFG_W'(cfg_dim[t]);
        number_of_bits       = CFG_W'(cfg_bits[t]);
        started              = 1'b0;
        dispatch_axb_a_wr_en = 1'b0;
        x_wr_credit_counter  = '0;
        rst_n                = 1'b0;
        repeat (5)
            @(negedge clk);
        prepare_test(t);
        rst_n = 1'b1;
        if (t == 0)
            repeat (10)
            begin
                @(negedge clk);  // idle after reset
                check_equal(64'(dispatch_axb_a_almost_full), 64'd0, "almost_full after reset");
                check_equal(64'(dot_product_valid), 64'd0, "valid after reset");
            end
        fork
            write_words();
            drive_run(t);
        join
        repeat (50)
            @(negedge clk);  // monitor catches any result past the last
    endtask

    // results come in sample order per bank and never before start
    always @(negedge clk)
    begin
        for (int b = 0; b < NUM_BANKS; b++)
            if (dot_product_valid[b] === 1'b1)
            begin
                check_equal(64'(started), 64'd1, $sformatf("bank %0d result before start", b));
                check_equal(64'(exp_q[b].size() != 0), 64'd1,
                            $sformatf("bank %0d result with none expected", b));
                check_equal(64'(dot_product[b]), 64'(exp_q[b].pop_front()),
                            $sformatf("bank %0d dot product", b));
                got_count[b]++;
            end
    end

    function automatic longint run_budget_ns();
        longint cycles;
        cycles = 0;
        for (int t = 0; t < N_TESTS; t++)
            cycles += longint'(cfg_epochs[t]) * cfg_samples[t] * cfg_bits[t]
                      * ((cfg_dim[t] + BITS_PER_BANK - 1) / BITS_PER_BANK)
                      + 300 + (cfg_hold[t] ? STALL_CYCLES : 0);  // reset drain and stall margin
        return 2 * cycles * CLK_PERIOD;
    endfunction

    initial
    begin
        #(run_budget_ns());
        $display("watchdog expired after %0d ns, the DUT stopped producing results",
                 run_budget_ns());
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial
    begin
        rst_n                = 1'b0;
        started              = 1'b0;
        number_of_epochs     = '0;
        number_of_samples    = '0;
        dimension            = '0;
        number_of_bits       = '0;
        dispatch_axb_a_data  = '0;
        dispatch_axb_a_wr_en = 1'b0;
        x_wr_credit_counter  = '0;
        for (int t = 0; t < N_TESTS; t++)
            run_test(t);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== files.f ====
source/sgd_pkg.sv
source/fifo_rd_if.sv
source/sample_fifo.sv
source/dot_control.sv
source/adder_tree.sv
source/bank_accumulator.sv
source/sgd_dot_product.sv
bench/tb_sgd_dot_product.sv

// ==== source/adder_tree.sv ====
/*
 * adder_tree
 * pipelined binary adder tree, one register level per tree level,
 * latency TREE_DEPTH cycles with a valid bit alongside
 */
module adder_tree (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic signed [sgd_pkg::X_WIDTH-1:0] in_data [sgd_pkg::BITS_PER_BANK],
    input  logic                               in_valid,
    output logic signed [sgd_pkg::X_WIDTH-1:0] out_data,
    output logic                               out_valid
);
    import sgd_pkg::*;

    // heap layout, node k sums children 2k and 2k+1, leaves are the inputs
    logic signed [X_WIDTH-1:0] node [1:BITS_PER_BANK-1];
    logic [TREE_DEPTH-1:0]     valid_pipe;

    genvar k;
    generate
        for (k = 1; k < BITS_PER_BANK; k++)
        begin : g_node
            if (2 * k >= BITS_PER_BANK)
            begin : g_leaf
                always_ff @(posedge clk)
                    node[k] <= in_data[2*k-BITS_PER_BANK] + in_data[2*k+1-BITS_PER_BANK];
            end
            else
            begin : g_inner
                always_ff @(posedge clk)
                    node[k] <= node[2*k] + node[2*k+1];  // wraps at X_WIDTH
            end
        end
    endgenerate

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[TREE_DEPTH-2:0], in_valid};
    end

    assign out_data  = node[1];  // root
    assign out_valid = valid_pipe[TREE_DEPTH-1];

endmodule

// ==== source/bank_accumulator.sv ====
/*
 * bank_accumulator
 * one bank: masks x with its a bits, sums them in the adder tree,
 * weights each bit-plane sum by 2^-(bit+1) and accumulates the
 * fixed-point dot product of one sample
 */
module bank_accumulator #(
    parameter int BANK_ID = 0
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    fifo_rd_if.bank                              rd,
    input  logic [sgd_pkg::X_WORD_W-1:0]         x_rd_data,
    input  logic [sgd_pkg::BIT_IDX_W-1:0]        bits_minus_1,
    input  logic [sgd_pkg::CHUNK_W-1:0]          chunks_minus_1,
    output logic signed [sgd_pkg::DOT_W-1:0]     dot_product,
    output logic                                 dot_product_valid
);
    import sgd_pkg::*;

    logic [BITS_PER_BANK-1:0]  a_reg;
    logic signed [X_WIDTH-1:0] x_reg [BITS_PER_BANK];
    logic signed [X_WIDTH-1:0] masked [BITS_PER_BANK];
    logic                      in_valid;
    logic signed [X_WIDTH-1:0] tree_sum;
    logic                      tree_valid;
    logic [BIT_IDX_W-1:0]      bit_idx;
    logic [CHUNK_W-1:0]        chunk_idx;
    logic signed [ACC_WIDTH-1:0] widened;
    logic signed [ACC_WIDTH-1:0] shifted;
    logic                      shift_valid;
    logic                      shift_first;
    logic                      shift_last;
    logic signed [ACC_WIDTH-1:0] acc;

    // a slice and x chunk land on the same edge
    always_ff @(posedge clk)
    begin
        a_reg <= rd.rd_data[BANK_ID*BITS_PER_BANK +: BITS_PER_BANK];
        for (int j = 0; j < BITS_PER_BANK; j++)
            x_reg[j] <= x_rd_data[j*X_WIDTH +: X_WIDTH];
    end

    always_comb
        for (int j = 0; j < BITS_PER_BANK; j++)
            masked[j] = a_reg[j] ? x_reg[j] : '0;  // a bit selects x

    adder_tree u_tree (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (masked),
        .in_valid  (in_valid),
        .out_data  (tree_sum),
        .out_valid (tree_valid)
    );

    assign widened = {tree_sum, {FRAC_BITS{1'b0}}};  // room below the lsb

    // position of each tree sum within the sample
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            in_valid          <= 1'b0;
            bit_idx           <= '0;
            chunk_idx         <= '0;
            shift_valid       <= 1'b0;
            dot_product_valid <= 1'b0;
        end
        else
        begin
            in_valid          <= rd.rd_valid;
            shift_valid       <= tree_valid;
            dot_product_valid <= shift_valid && shift_last;  // with the final add
            if (tree_valid)
            begin
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == bits_minus_1)
                begin
                    bit_idx   <= '0;
                    chunk_idx <= chunk_idx + 1'b1;
                    if (chunk_idx == chunks_minus_1)
                        chunk_idx <= '0;  // next sample
                end
            end
        end
    end

    // bit-plane weight 2^-(bit+1)
    always_ff @(posedge clk)
    begin
        shifted     <= widened >>> ({1'b0, bit_idx} + 6'd1);
        shift_first <= (chunk_idx == '0) && (bit_idx == '0);
        shift_last  <= (chunk_idx == chunks_minus_1) && (bit_idx == bits_minus_1);
        if (shift_valid)
            acc <= shift_first ? shifted : acc + shifted;  // first term loads
    end

    assign dot_product = acc[ACC_WIDTH-1 -: DOT_W];  // drop the extra fraction

endmodule

// ==== source/dot_control.sv ====
/*
 * dot_control
 * start synchronizer, configuration snapshot and the FSM that walks
 * epochs, sample groups, chunks and bit-planes, popping one FIFO word
 * per step and addressing x once per chunk
 */
module dot_control (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          started,
    input  logic [sgd_pkg::CFG_W-1:0]     number_of_epochs,
    input  logic [sgd_pkg::CFG_W-1:0]     number_of_samples,
    input  logic [sgd_pkg::CFG_W-1:0]     dimension,
    input  logic [sgd_pkg::CFG_W-1:0]     number_of_bits,
    input  logic [sgd_pkg::CREDIT_W-1:0]  x_wr_credit_counter,
    output logic [sgd_pkg::X_ADDR_W-1:0]  x_rd_addr,
    fifo_rd_if.ctrl                       rd,
    output logic [sgd_pkg::BIT_IDX_W-1:0] bits_minus_1,
    output logic [sgd_pkg::CHUNK_W-1:0]   chunks_minus_1
);
    import sgd_pkg::*;

    dot_state_t            state;
    logic [2:0]            start_sync;
    logic [EPOCH_W-1:0]    epochs_r;
    logic [CFG_W-1:0]      samples_r;
    logic [CFG_W-1:0]      chunks_w;
    logic [CREDIT_W-1:0]   rd_credit;
    logic [CREDIT_LAT-1:0] credit_pipe;
    logic [2:0]            credit_hold;  // stale compare guard after a consume
    logic [EPOCH_W-1:0]    epoch_idx;
    logic [CFG_W-1:0]      sample_idx;
    logic [CHUNK_W-1:0]    chunk_idx;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic                  credit_ok;
    logic                  rd_safe;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            start_sync <= '0;
        else
            start_sync <= {start_sync[1:0], started};
    end

    // ceil(dimension / BITS_PER_BANK)
    assign chunks_w = (dimension >> TREE_DEPTH) + CFG_W'(dimension[TREE_DEPTH-1:0] != '0);

    // config is sampled every cycle, held stable by the host while running
    always_ff @(posedge clk)
    begin
        epochs_r       <= number_of_epochs[EPOCH_W-1:0];
        samples_r      <= number_of_samples;
        bits_minus_1   <= number_of_bits[BIT_IDX_W-1:0] - 1'b1;
        chunks_minus_1 <= CHUNK_W'(chunks_w - 1'b1);
    end

    // x written ahead of x read, compare goes through CREDIT_LAT stages
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            credit_pipe <= '0;
        else
            credit_pipe <= {credit_pipe[CREDIT_LAT-2:0], x_wr_credit_counter != rd_credit};
    end

    assign credit_ok = credit_pipe[CREDIT_LAT-1] && (credit_hold == '0);

    // one pop already in flight may drain the last word
    assign rd_safe = !(rd.empty || ((rd.count == FIFO_CNT_W'(1)) && rd.rd_en));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state       <= st_idle;
            rd.rd_en    <= 1'b0;
            x_rd_addr   <= '0;
            rd_credit   <= '0;
            credit_hold <= '0;
            epoch_idx   <= '0;
            sample_idx  <= '0;
            chunk_idx   <= '0;
            bit_idx     <= '0;
        end
        else
        begin
            rd.rd_en <= 1'b0;  // single-cycle pops
            if (credit_hold != '0)
                credit_hold <= credit_hold - 1'b1;
            case (state)
                st_idle:
                    if (start_sync[2])
                        state <= st_starting;
                st_starting:
                begin
                    epoch_idx <= '0;
                    rd_credit <= '0;
                    state     <= st_epoch;
                end
                st_epoch:
                begin
                    sample_idx <= '0;
                    if (epoch_idx == epochs_r)
                        state <= st_done;  // all epochs run
                    else
                    begin
                        epoch_idx <= epoch_idx + 1'b1;
                        state     <= st_epoch_sample;
                    end
                end
                st_epoch_sample:
                    state <= st_sample;
                st_sample:
                begin
                    chunk_idx <= '0;
                    bit_idx   <= '0;
                    if (sample_idx == samples_r)
                        state <= st_epoch;
                    else
                    begin
                        sample_idx <= sample_idx + CFG_W'(NUM_BANKS);  // one group
                        state      <= st_check_x;
                    end
                end
                st_check_x:
                    if (credit_ok)
                    begin
                        rd_credit   <= rd_credit + 1'b1;  // one credit per group
                        credit_hold <= 3'(CREDIT_LAT);
                        state       <= st_computing;
                    end
                st_computing:
                    if (rd_safe)  // stall while FIFO runs dry
                    begin
                        rd.rd_en <= 1'b1;
                        if (bit_idx == '0)
                            x_rd_addr <= chunk_idx[X_ADDR_W-1:0];  // new chunk
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bits_minus_1)
                        begin
                            bit_idx   <= '0;
                            chunk_idx <= chunk_idx + 1'b1;
                            if (chunk_idx == chunks_minus_1)
                                state <= st_sample;
                        end
                    end
                st_done:
                    state <= st_done;  // until reset
                default:
                    state <= st_idle;
            endcase
        end
    end

endmodule

// ==== source/fifo_rd_if.sv ====
/*
 * fifo_rd_if
 * read side of the sample FIFO, popped by control and consumed by
 * every bank; rd_valid follows rd_en by one cycle with the word
 */
interface fifo_rd_if;
    import sgd_pkg::*;

    logic                  rd_en;     // pop request
    logic                  empty;
    logic [FIFO_CNT_W-1:0] count;     // occupancy
    logic [A_WORD_W-1:0]   rd_data;   // one bit-plane, all banks
    logic                  rd_valid;

    modport fifo (input rd_en, output empty, output count, output rd_data, output rd_valid);
    modport ctrl (output rd_en, input empty, input count);
    modport bank (input rd_data, input rd_valid);

endinterface

// ==== source/sample_fifo.sv ====
/*
 * sample_fifo
 * register-array FIFO for bit-plane words of the sample vectors,
 * with occupancy count, almost-full and a registered read port
 */
module sample_fifo (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  logic [sgd_pkg::A_WORD_W-1:0]  wr_data,
    output logic                          almost_full,
    fifo_rd_if.fifo                       rd
);
    import sgd_pkg::*;

    logic [A_WORD_W-1:0]        mem [FIFO_DEPTH];
    logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
    logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0]      count;
    logic                       do_wr;
    logic                       do_rd;

    assign do_wr = wr_en && (count != FIFO_CNT_W'(FIFO_DEPTH));  // word lost when full
    assign do_rd = rd.rd_en && (count != '0);

    assign rd.empty = (count == '0);
    assign rd.count = count;

    // fewer than ALMOST_FULL_MARGIN free slots
    assign almost_full = (count > FIFO_CNT_W'(FIFO_DEPTH - ALMOST_FULL_MARGIN));

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
        if (do_rd)
            rd.rd_data <= mem[rd_ptr];  // word lands with rd_valid
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            rd.rd_valid <= 1'b0;
        end
        else
        begin
            rd.rd_valid <= do_rd;
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;  // pointers wrap at depth
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

// ==== source/sgd_dot_product.sv ====
/*
 * sgd_dot_product
 * top of the dot-product engine, input register in front of the
 * sample FIFO, control FSM and one accumulator per bank
 */
module sgd_dot_product (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             started,
    input  logic [sgd_pkg::CFG_W-1:0]        number_of_epochs,
    input  logic [sgd_pkg::CFG_W-1:0]        number_of_samples,
    input  logic [sgd_pkg::CFG_W-1:0]        dimension,
    input  logic [sgd_pkg::CFG_W-1:0]        number_of_bits,
    input  logic [sgd_pkg::A_WORD_W-1:0]     dispatch_axb_a_data,
    input  logic                             dispatch_axb_a_wr_en,
    output logic                             dispatch_axb_a_almost_full,
    input  logic [sgd_pkg::CREDIT_W-1:0]     x_wr_credit_counter,
    output logic [sgd_pkg::X_ADDR_W-1:0]     x_rd_addr,
    input  logic [sgd_pkg::X_WORD_W-1:0]     x_rd_data,
    output logic signed [sgd_pkg::DOT_W-1:0] dot_product [sgd_pkg::NUM_BANKS],
    output logic [sgd_pkg::NUM_BANKS-1:0]    dot_product_valid
);
    import sgd_pkg::*;

    logic [A_WORD_W-1:0]  a_data_r;
    logic                 a_wr_en_r;
    logic [BIT_IDX_W-1:0] bits_minus_1;
    logic [CHUNK_W-1:0]   chunks_minus_1;

    fifo_rd_if rd_bus ();

    // one cycle of register ahead of the FIFO write
    always_ff @(posedge clk)
    begin
        a_data_r <= dispatch_axb_a_data;
        if (!rst_n)
            a_wr_en_r <= 1'b0;
        else
            a_wr_en_r <= dispatch_axb_a_wr_en;
    end

    sample_fifo u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (a_wr_en_r),
        .wr_data     (a_data_r),
        .almost_full (dispatch_axb_a_almost_full),
        .rd          (rd_bus.fifo)
    );

    dot_control u_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .started             (started),
        .number_of_epochs    (number_of_epochs),
        .number_of_samples   (number_of_samples),
        .dimension           (dimension),
        .number_of_bits      (number_of_bits),
        .x_wr_credit_counter (x_wr_credit_counter),
        .x_rd_addr           (x_rd_addr),
        .rd                  (rd_bus.ctrl),
        .bits_minus_1        (bits_minus_1),
        .chunks_minus_1      (chunks_minus_1)
    );

    genvar b;
    generate
        for (b = 0; b < NUM_BANKS; b++)
        begin : g_bank
            bank_accumulator #(
                .BANK_ID (b)
            ) u_bank (
                .clk               (clk),
                .rst_n             (rst_n),
                .rd                (rd_bus.bank),
                .x_rd_data         (x_rd_data),
                .bits_minus_1      (bits_minus_1),
                .chunks_minus_1    (chunks_minus_1),
                .dot_product       (dot_product[b]),
                .dot_product_valid (dot_product_valid[b])
            );
        end
    endgenerate

endmodule

// ==== source/sgd_pkg.sv ====
/*
 * sgd_pkg
 * shared sizes, widths and the control FSM state type for the
 * bit-serial dot-product engine
 */
package sgd_pkg;

    // bank geometry
    localparam int NUM_BANKS          = 2;   // samples side by side
    localparam int BITS_PER_BANK      = 8;   // features per chunk
    localparam int TREE_DEPTH         = 3;   // log2(BITS_PER_BANK)

    // data widths
    localparam int X_WIDTH            = 32;
    localparam int A_WORD_W           = NUM_BANKS * BITS_PER_BANK;
    localparam int X_WORD_W           = BITS_PER_BANK * X_WIDTH;
    localparam int CFG_W              = 32;  // config registers
    localparam int DOT_W              = 32;  // result width per bank

    // sample FIFO
    localparam int FIFO_DEPTH_BITS    = 6;
    localparam int FIFO_DEPTH         = 1 << FIFO_DEPTH_BITS;
    localparam int FIFO_CNT_W         = FIFO_DEPTH_BITS + 1;  // 0..FIFO_DEPTH
    localparam int ALMOST_FULL_MARGIN = 4;   // free slots at almost-full

    // loop counters
    localparam int X_ADDR_W           = 6;
    localparam int BIT_IDX_W          = 5;
    localparam int CHUNK_W            = 12;
    localparam int EPOCH_W            = 10;
    localparam int CREDIT_W           = 8;
    localparam int CREDIT_LAT         = 4;   // stages on the credit compare

    // fixed point accumulator, extra fraction below the output
    localparam int FRAC_BITS          = 4;
    localparam int ACC_WIDTH          = X_WIDTH + FRAC_BITS;

    typedef enum logic [2:0] {
        st_idle,
        st_starting,      // clear epoch and credit state
        st_epoch,         // epoch bound check
        st_epoch_sample,
        st_sample,        // next sample group or end of epoch
        st_check_x,       // wait for an x credit
        st_computing,     // chunk and bit-plane loops
        st_done
    } dot_state_t;

endpackage
